/* dv/phasealign_tb.sv */
`timescale 1ns/10ps

// phase aligner testbench, shifter model plus token stream around a test window
module phasealign_tb;

  localparam int SRCH_TIMER_W = 8;           // 256-cycle search per phase
  localparam int CTKN_CNT_W   = 4;           // 16 tokens make blanking
  localparam int N_TESTS      = 3;
  localparam int CYC_PER_PHS  = 400;         // watchdog budget per phase tried
  localparam int PSDONE_LAT   = 3;           // shifter answer delay
  localparam int BURST_LEN    = 20;          // tokens per blanking burst
  localparam int BURST_GAP    = 64;          // burst repeat period

  // window [lo, hi] of open-eye phases and the overflow limit per test
  localparam int LO_TBL  [N_TESTS] = '{12, 1, 10};
  localparam int HI_TBL  [N_TESTS] = '{30, 0, 13};   // hi < lo means no eye at all
  localparam int LIM_TBL [N_TESTS] = '{200, 40, 60};

  typedef struct packed {
    logic        aligned;                    // 1 psaligned, 0 psalgnerr
    logic        eye_vld;                    // valid eye seen on the way
    logic [15:0] phase;                      // shifter phase at the end
  } expect_t;

  logic                  clk;
  logic                  rst;
  logic                  rst_req;
  phasealign_pkg::word_t sdata;
  logic                  psdone;
  logic                  dcm_ovflw;
  logic                  psen;
  logic                  psincdec;
  logic                  psaligned;
  logic                  psalgnerr;
  logic                  found_vld_openeye;

  string       test_name;
  int          win_lo;
  int          win_hi;
  int          ovf_limit;
  int          tb_phase;                     // shifter position
  int          done_cnt;                     // cycles left to psdone
  logic        step_pending;                 // psen seen, psdone not yet given
  logic        psen_q;
  int          slot;                         // position in the burst period
  logic        burst_on;                     // burst latched at slot 0
  logic [31:0] lfsr;
  logic        armed;                        // compare waits for a result
  expect_t     exp_r;

  tb_clk_gen clk_gen_i (.rst_req(rst_req), .clk(clk), .rst(rst));

  phasealign_top #(
    .CTKN_CNT_W   (CTKN_CNT_W),
    .SRCH_TIMER_W (SRCH_TIMER_W)
  ) dut_i (
    .clk (clk), .rst (rst), .sdata (sdata), .psdone (psdone), .dcm_ovflw (dcm_ovflw),
    .psen (psen), .psincdec (psincdec), .psaligned (psaligned), .psalgnerr (psalgnerr),
    .found_vld_openeye (found_vld_openeye)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_bit(input string what, input logic exp_v, input logic act_v);
    assert (act_v === exp_v)
      else report_failure($sformatf("mismatch %s %s expected %0b actual %0b",
                                    test_name, what, exp_v, act_v));
  endtask

  function automatic string name_of(input int t);
    case (t)
      0:       return "wide_eye";
      1:       return "no_eye";
      default: return "narrow_eye";
    endcase
  endfunction

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic is_token(input phasealign_pkg::word_t w);
    return (w == phasealign_pkg::CTRL_TOKEN0) || (w == phasealign_pkg::CTRL_TOKEN1) ||
           (w == phasealign_pkg::CTRL_TOKEN2) || (w == phasealign_pkg::CTRL_TOKEN3);
  endfunction

  function automatic phasealign_pkg::word_t random_word();
    phasealign_pkg::word_t w;
    int                    b;
    w = '0;
    for (b = 0; b < 10; b++) begin
      lfsr = lfsr_step(lfsr);
      w    = {w[8:0], lfsr[0]};
    end
    if (is_token(w))
      w[0] = ~w[0];                          // no stray token outside blanking
    return w;
  endfunction

  function automatic phasealign_pkg::word_t token_at(input int n);
    case (n % 4)                             // walk through all four codes
      0:       return phasealign_pkg::CTRL_TOKEN0;
      1:       return phasealign_pkg::CTRL_TOKEN1;
      2:       return phasealign_pkg::CTRL_TOKEN2;
      default: return phasealign_pkg::CTRL_TOKEN3;
    endcase
  endfunction

  // expected outcome: a valid eye needs 6 open phases after a jitter phase
  function automatic expect_t ref_result(input int lo, input int hi, input int limit);
    expect_t r;
    int      len;
    len       = hi - lo + 1;                 // zero or less for an empty window
    r.eye_vld = (lo > 0) && (len >= 6) && (lo + 5 < limit);
    r.aligned = r.eye_vld && (hi + 1 < limit);   // right edge must be reachable
    r.phase   = r.aligned ? 16'((lo + hi + 1) / 2) : 16'(limit);
    return r;
  endfunction

  function automatic int phases_tried(input int lo, input int hi, input int limit);
    expect_t r;
    r = ref_result(lo, hi, limit);
    if (r.aligned)
      return (hi + 2) + (hi + 1 - int'(r.phase));   // sweep up, then back to center
    return limit + 1;
  endfunction

  //////////////////////////////
  // shifter model and stream
  //////////////////////////////
  always @(negedge clk) begin
    if (rst) begin
      tb_phase     = 0;
      done_cnt     = 0;
      step_pending = 1'b0;
      psen_q       = 1'b0;
      psdone       = 1'b0;
      slot         = 0;
      burst_on     = 1'b0;
    end else begin
      assert (!(psen && psen_q))
        else report_failure($sformatf("%s: psen stayed high for two cycles", test_name));
      assert (!(psen && step_pending))
        else report_failure($sformatf("%s: psen came before psdone", test_name));
      psen_q = psen;
      psdone = 1'b0;
      if (done_cnt > 0) begin
        done_cnt = done_cnt - 1;
        if (done_cnt == 0) begin
          psdone       = 1'b1;               // one-cycle answer
          step_pending = 1'b0;
        end
      end
      if (psen) begin
        tb_phase     = psincdec ? tb_phase + 1 : tb_phase - 1;
        done_cnt     = PSDONE_LAT;
        step_pending = 1'b1;
      end
      if (slot == 0)
        burst_on = (tb_phase >= win_lo) && (tb_phase <= win_hi);   // eye open here
      if (burst_on && slot < BURST_LEN)
        sdata = token_at(slot);
      else
        sdata = random_word();
      slot = (slot + 1) % BURST_GAP;
    end
    dcm_ovflw = (tb_phase >= ovf_limit);     // level, read after psdone
  end

  //////////////////////////////
  // compare and sequencing
  //////////////////////////////
  always @(negedge clk) begin
    if (armed && !rst && (psaligned || psalgnerr)) begin
      exp_r = ref_result(win_lo, win_hi, ovf_limit);
      check_bit("psaligned", exp_r.aligned, psaligned);
      check_bit("psalgnerr", !exp_r.aligned, psalgnerr);
      check_bit("found_vld_openeye", exp_r.eye_vld, found_vld_openeye);
      assert (tb_phase == int'(exp_r.phase))
        else report_failure($sformatf("mismatch %s phase expected %0d actual %0d",
                                      test_name, exp_r.phase, tb_phase));
      armed = 1'b0;
    end
  end

  task automatic check_reset_values();
    check_bit("psen", 1'b0, psen);
    check_bit("psincdec", 1'b0, psincdec);
    check_bit("psaligned", 1'b0, psaligned);
    check_bit("psalgnerr", 1'b0, psalgnerr);
    check_bit("found_vld_openeye", 1'b0, found_vld_openeye);
  endtask

  task automatic run_test(input int t);
    @(negedge clk);
    test_name = name_of(t);
    win_lo    = LO_TBL[t];
    win_hi    = HI_TBL[t];
    ovf_limit = LIM_TBL[t];
    rst_req   = 1'b1;                        // fresh reset for every test
    wait (rst);
    rst_req   = 1'b0;
    wait (!rst);
    check_reset_values();
    armed = 1'b1;
    wait (!armed);                           // compare process has seen the result
  endtask

  initial begin
    int t;
    rst_req   = 1'b0;
    sdata     = '0;
    psdone    = 1'b0;
    dcm_ovflw = 1'b0;
    lfsr      = 32'd90412;
    win_lo    = 1;
    win_hi    = 0;
    ovf_limit = 1000;
    armed     = 1'b0;
    test_name = "reset_values";
    wait (!rst);
    check_reset_values();
    for (t = 0; t < N_TESTS; t++)
      run_test(t);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // budget follows the phases each test sweeps through
  initial begin
    int cycles;
    int i;
    cycles = 2000;
    for (i = 0; i < N_TESTS; i++)
      cycles = cycles + phases_tried(LO_TBL[i], HI_TBL[i], LIM_TBL[i]) * CYC_PER_PHS;
    repeat (cycles) @(posedge clk);
    report_failure($sformatf("timeout after %0d cycles in test %s", cycles, test_name));
  end

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/10ps

// free-running clock and a three-cycle reset that the testbench can re-arm
module tb_clk_gen #(
  parameter int PERIOD_NS = 20
) (
  input  logic rst_req,   // rising edge starts a fresh reset
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset edges land on the falling edge, away from the dut flops
  initial begin
    rst = 1'b1;
    forever begin
      repeat (3) @(negedge clk);
      rst = 1'b0;
      @(posedge rst_req);
      rst = 1'b1;
    end
  end

endmodule

/* files.f */
src/phasealign_pkg.sv
src/align_step_if.sv
src/ctrl_token_detect.sv
src/blank_timers.sv
src/phase_tracker.sv
src/align_fsm.sv
src/phasealign_top.sv
dv/tb_clk_gen.sv
dv/phasealign_tb.sv

/* run.sh */
#!/bin/sh
# build and run the phase aligner testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module phasealign_tb \
  -f files.f \
  -Mdir obj_dir -o phasealign_sim

# exit status of the simulation is the test result
./obj_dir/phasealign_sim

/* src/align_fsm.sv */
`timescale 1ns/10ps

// phase alignment state machine, drives the shifter and the result flags
module align_fsm (
  input  logic       clk,
  input  logic       rst,
  input  logic       rcvd_ctkn,   // token on the stream
  input  logic       blnkbgn,     // token run starts
  input  logic       srch_tout,   // no blanking found in time
  input  logic       cnt_tout,    // token run long enough
  input  logic       psdone,      // shifter finished a step
  input  logic       dcm_ovflw,   // shifter at end of range
  output logic       srch_rst,
  output logic       cnt_rst,
  output logic       psen,
  output logic       psincdec,    // 1 = increment, valid with psen
  output logic       psaligned,
  output logic       psalgnerr,
  align_step_if.fsm  step
);

  phasealign_pkg::align_state_t cstate;
  phasealign_pkg::align_state_t nstate;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cstate <= phasealign_pkg::IDLE;   // counter starts at zero, no initial sweep
    end else begin
      cstate <= nstate;
    end
  end

  ////////////////////////////////
  // next state
  ////////////////////////////////
  always_comb begin
    nstate = cstate;
    unique case (cstate)
      phasealign_pkg::IDLE: begin
        if (blnkbgn)
          nstate = phasealign_pkg::RCVDCTKN;
        else if (srch_tout)
          nstate = phasealign_pkg::JTRZONE;          // no blanking at this phase
        else if (step.ps_cnt_full)
          nstate = phasealign_pkg::PSALGNERR;        // whole range tried
      end
      phasealign_pkg::RCVDCTKN: begin
        if (!rcvd_ctkn)
          nstate = phasealign_pkg::IDLE;             // run broken, keep searching
        else if (cnt_tout)
          nstate = phasealign_pkg::EYEOPENS;
      end
      phasealign_pkg::EYEOPENS:
        nstate = phasealign_pkg::PSINC;
      phasealign_pkg::JTRZONE:
        // past a valid eye the jitter zone marks its right edge
        nstate = step.found_vld_openeye ? phasealign_pkg::PSDEC : phasealign_pkg::PSINC;
      phasealign_pkg::PSINC:
        nstate = phasealign_pkg::PSINCDONE;
      phasealign_pkg::PSINCDONE: begin
        if (psdone)
          nstate = phasealign_pkg::TESTOVFLW;
      end
      phasealign_pkg::TESTOVFLW:
        nstate = dcm_ovflw ? phasealign_pkg::PSALGNERR : phasealign_pkg::IDLE;
      phasealign_pkg::PSDEC:
        nstate = phasealign_pkg::PSDECDONE;
      phasealign_pkg::PSDECDONE: begin
        if (psdone)
          nstate = step.center_reached ? phasealign_pkg::PSALGND : phasealign_pkg::PSDEC;
      end
      phasealign_pkg::PSALGND:   nstate = phasealign_pkg::PSALGND;
      phasealign_pkg::PSALGNERR: nstate = phasealign_pkg::PSALGNERR;
      default:                   nstate = phasealign_pkg::IDLE;
    endcase
  end

  ////////////////////////////////
  // registered outputs per state
  ////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      psen          <= 1'b0;
      psincdec      <= 1'b0;
      psaligned     <= 1'b0;
      psalgnerr     <= 1'b0;
      srch_rst      <= 1'b1;   // timers held until first idle
      cnt_rst       <= 1'b1;
      step.step_inc <= 1'b0;
      step.step_dec <= 1'b0;
      step.eye_mark <= 1'b0;
      step.jtr_mark <= 1'b0;
    end else begin
      psen          <= 1'b0;   // strobes last one cycle
      step.step_inc <= 1'b0;
      step.step_dec <= 1'b0;
      step.eye_mark <= 1'b0;
      step.jtr_mark <= 1'b0;
      srch_rst      <= 1'b1;   // timers only run while searching
      cnt_rst       <= 1'b1;
      unique case (cstate)
        phasealign_pkg::IDLE: srch_rst <= 1'b0;
        phasealign_pkg::RCVDCTKN: begin
          srch_rst <= 1'b0;
          cnt_rst  <= 1'b0;    // count the run
        end
        phasealign_pkg::EYEOPENS: step.eye_mark <= 1'b1;
        phasealign_pkg::JTRZONE:  step.jtr_mark <= 1'b1;
        phasealign_pkg::PSINC: begin
          psen          <= 1'b1;
          psincdec      <= 1'b1;
          step.step_inc <= 1'b1;
        end
        phasealign_pkg::PSDEC: begin
          psen          <= 1'b1;
          psincdec      <= 1'b0;
          step.step_dec <= 1'b1;
        end
        phasealign_pkg::PSALGND:   psaligned <= 1'b1;   // sticky, terminal state
        phasealign_pkg::PSALGNERR: psalgnerr <= 1'b1;
        default: ;
      endcase
    end
  end

  // every step waits in a done state, so psen can never repeat at once
  a_psen_pulse: assert property (@(posedge clk) disable iff (rst) psen |=> !psen)
    else $error("psen high for two cycles");

  a_result_excl: assert property (@(posedge clk) disable iff (rst)
    !(psaligned && psalgnerr))
    else $error("psaligned and psalgnerr both set");

endmodule

/* src/align_step_if.sv */
`timescale 1ns/10ps

// step and mark strobes from the fsm, eye status back from the tracker
interface align_step_if;

  logic                   step_inc;          // increment issued, same cycle as psen
  logic                   step_dec;          // decrement issued, same cycle as psen
  logic                   eye_mark;          // current phase is open eye
  logic                   jtr_mark;          // current phase is jitter zone

  logic                   found_vld_openeye; // long enough open-eye run seen
  logic                   ps_cnt_full;       // phase counter hit half range
  logic                   center_reached;    // phase sits at the eye center
  phasealign_pkg::phase_t ps_cnt;            // current phase position

  modport fsm (
    output step_inc, step_dec, eye_mark, jtr_mark,
    input  found_vld_openeye, ps_cnt_full, center_reached
  );

  modport tracker (
    input  step_inc, step_dec, eye_mark, jtr_mark,
    output found_vld_openeye, ps_cnt_full, center_reached, ps_cnt
  );

  // observer view for debug probes
  modport mon (
    input step_inc, step_dec, eye_mark, jtr_mark,
    input found_vld_openeye, ps_cnt_full, center_reached, ps_cnt
  );

endinterface

/* src/blank_timers.sv */
`timescale 1ns/10ps

// search timer for blanking and run-length counter for control tokens
module blank_timers #(
  parameter int CTKN_CNT_W   = 4,   // run of 2^CTKN_CNT_W tokens counts as blanking
  parameter int SRCH_TIMER_W = 23   // search gives up after 2^SRCH_TIMER_W cycles
) (
  input  logic clk,
  input  logic rst,
  input  logic srch_rst,            // hold search timer at zero
  input  logic cnt_rst,             // hold token counter at zero
  output logic srch_tout,           // search timer wrapped
  output logic cnt_tout             // enough tokens in a row
);

  logic [SRCH_TIMER_W-1:0] srch_timer;
  logic [CTKN_CNT_W-1:0]   ctkn_cnt;

  ////////////////////////////////
  // control token search timer
  ////////////////////////////////
  // dvi blanking repeats at least every 50 ms, default width covers more than that
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      srch_timer <= '0;
      srch_tout  <= 1'b0;
    end else begin
      srch_timer <= srch_rst ? '0 : srch_timer + 1'b1;       // free running otherwise
      srch_tout  <= (srch_timer == '1) && !srch_rst;         // clear wins over a late hit
    end
  end

  ////////////////////////////////
  // control token run counter
  ////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctkn_cnt <= '0;
      cnt_tout <= 1'b0;
    end else begin
      ctkn_cnt <= cnt_rst ? '0 : ctkn_cnt + 1'b1;
      cnt_tout <= (ctkn_cnt == '1);                          // registered all-ones
    end
  end

  // a broken run must never look like a full one to the fsm
  a_cnt_tout_after_rst: assert property (@(posedge clk) disable iff (rst)
    cnt_rst |=> !cnt_tout)
    else $error("cnt_tout high right after cnt_rst");

endmodule

/* src/ctrl_token_detect.sv */
`timescale 1ns/10ps

// finds control tokens in the captured word stream and flags the start of a run
module ctrl_token_detect (
  input  logic                  clk,
  input  logic                  rst,
  input  phasealign_pkg::word_t sdata,      // word from the recovered clock domain
  output logic                  rcvd_ctkn,  // token present, 3 cycles behind sdata
  output logic                  blnkbgn     // one pulse on the first token of a run
);

  phasealign_pkg::word_t sdata_q;           // input stage, eases timing off the serdes
  logic [3:0]            tkn_q;             // one registered match per token
  logic                  rcvd_ctkn_q;       // delayed copy for edge detect
  logic                  sdata_tkn;         // raw input is one of the four codes

  ////////////////////////////////
  // token match pipeline
  ////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sdata_q     <= '0;
      tkn_q       <= '0;
      rcvd_ctkn   <= 1'b0;
      rcvd_ctkn_q <= 1'b0;
      blnkbgn     <= 1'b0;
    end else begin
      sdata_q     <= sdata;
      tkn_q[0]    <= (sdata_q == phasealign_pkg::CTRL_TOKEN0);
      tkn_q[1]    <= (sdata_q == phasealign_pkg::CTRL_TOKEN1);
      tkn_q[2]    <= (sdata_q == phasealign_pkg::CTRL_TOKEN2);
      tkn_q[3]    <= (sdata_q == phasealign_pkg::CTRL_TOKEN3);
      rcvd_ctkn   <= |tkn_q;                       // any of the four codes
      rcvd_ctkn_q <= rcvd_ctkn;
      blnkbgn     <= rcvd_ctkn & ~rcvd_ctkn_q;     // rising edge of the run
    end
  end

  // the first token of a run reaches blnkbgn four cycles after it sat on sdata
  assign sdata_tkn = (sdata == phasealign_pkg::CTRL_TOKEN0) ||
                     (sdata == phasealign_pkg::CTRL_TOKEN1) ||
                     (sdata == phasealign_pkg::CTRL_TOKEN2) ||
                     (sdata == phasealign_pkg::CTRL_TOKEN3);

  a_blnkbgn_latency: assert property (@(posedge clk) disable iff (rst)
    blnkbgn |-> $past(sdata_tkn, 4))
    else $error("blnkbgn without a token on sdata four cycles earlier");

endmodule

/* src/phase_tracker.sv */
`timescale 1ns/10ps

// tracks the phase position and decides where the eye is
module phase_tracker (
  input logic           clk,
  input logic           rst,
  align_step_if.tracker step
);

  phasealign_pkg::phase_t            ps_cnt;            // steps taken from reset
  phasealign_pkg::phase_t            openeye_bgn;       // first phase of current eye run
  phasealign_pkg::phase_t            jtrzone_bgn;       // first jitter phase past the eye
  phasealign_pkg::phase_t            last_openeye_pos;  // phase of latest open-eye mark
  phasealign_pkg::phase_t            eye_delta;         // distance to latest open eye
  logic [3:0]                        openeye_cnt;       // consecutive open-eye steps
  logic                              found_jtrzone;     // a jitter zone came first
  logic [phasealign_pkg::PS_CNT_W:0] bgn_sum;           // extra bit keeps the carry
  phasealign_pkg::phase_t            center;            // floor of the eye mean

  assign step.ps_cnt = ps_cnt;

  ////////////////////////////////
  // phase step counter
  ////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ps_cnt           <= '0;
      step.ps_cnt_full <= 1'b0;
    end else begin
      if (step.step_inc) begin
        ps_cnt <= ps_cnt + 1'b1;
      end else if (step.step_dec) begin
        ps_cnt <= ps_cnt - 1'b1;
      end
      step.ps_cnt_full <= ps_cnt[phasealign_pkg::PS_CNT_W-1];  // half range is the limit
    end
  end

  ////////////////////////////////
  // eye and jitter bookkeeping
  ////////////////////////////////
  assign eye_delta = ps_cnt - last_openeye_pos;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      openeye_bgn            <= '0;
      jtrzone_bgn            <= '0;
      last_openeye_pos       <= '0;
      openeye_cnt            <= '0;
      found_jtrzone          <= 1'b0;
      step.found_vld_openeye <= 1'b0;
    end else begin
      if (step.jtr_mark) begin
        jtrzone_bgn   <= ps_cnt;
        found_jtrzone <= 1'b1;
      end
      if (step.eye_mark) begin
        // only runs that start after a jitter zone are measured
        if (found_jtrzone) begin
          if (eye_delta == phasealign_pkg::phase_t'(1)) begin
            openeye_cnt <= openeye_cnt + 4'd1;
            if (openeye_cnt == phasealign_pkg::OPENEYE_FULL) begin
              step.found_vld_openeye <= 1'b1;           // sticky until rst
            end
          end else begin
            openeye_bgn <= ps_cnt;                      // run broken, start over here
            openeye_cnt <= '0;
          end
        end
        last_openeye_pos <= ps_cnt;
      end
    end
  end

  ////////////////////////////////
  // center compare
  ////////////////////////////////
  // (openeye_bgn + jtrzone_bgn) / 2, jtrzone_bgn always above openeye_bgn
  assign bgn_sum = {1'b0, openeye_bgn} + {1'b0, jtrzone_bgn};
  assign center  = bgn_sum[phasealign_pkg::PS_CNT_W:1];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      step.center_reached <= 1'b0;
    end else begin
      step.center_reached <= (ps_cnt == center);   // one cycle behind the counter
    end
  end

  // the fsm issues one step at a time
  a_single_step: assert property (@(posedge clk) disable iff (rst)
    !(step.step_inc && step.step_dec))
    else $error("step_inc and step_dec together");

endmodule

/* src/phasealign_pkg.sv */
package phasealign_pkg;

  ////////////////////////////////
  // tmds words and control codes
  ////////////////////////////////
  typedef logic [9:0] word_t;                        // one 10-bit tmds character

  localparam word_t CTRL_TOKEN0 = 10'b1101010100;    // c1c0 = 00
  localparam word_t CTRL_TOKEN1 = 10'b0010101011;    // c1c0 = 01
  localparam word_t CTRL_TOKEN2 = 10'b0101010100;    // c1c0 = 10
  localparam word_t CTRL_TOKEN3 = 10'b1010101011;    // c1c0 = 11

  ////////////////////////////////
  // phase bookkeeping
  ////////////////////////////////
  localparam int PS_CNT_W = 10;                      // msb doubles as the range limit
  typedef logic [PS_CNT_W-1:0] phase_t;

  // open-eye run length that makes the eye valid (counter value, not phases)
  localparam logic [3:0] OPENEYE_FULL = 4'd4;

  // one-hot alignment states
  typedef enum logic [10:0] {
    IDLE      = 11'b1 << 0,   // search for blanking at this phase
    RCVDCTKN  = 11'b1 << 1,   // token seen, counting the run
    EYEOPENS  = 11'b1 << 2,   // phase is open eye
    JTRZONE   = 11'b1 << 3,   // phase is jitter zone
    PSINC     = 11'b1 << 4,   // issue increment
    PSINCDONE = 11'b1 << 5,   // wait psdone after increment
    TESTOVFLW = 11'b1 << 6,   // look at shifter overflow
    PSDEC     = 11'b1 << 7,   // issue decrement
    PSDECDONE = 11'b1 << 8,   // wait psdone after decrement
    PSALGND   = 11'b1 << 9,   // aligned, terminal
    PSALGNERR = 11'b1 << 10   // failed, terminal
  } align_state_t;

endpackage

/* src/phasealign_top.sv */
`timescale 1ns/10ps

// tmds channel phase aligner, steps an external shifter to the eye center
module phasealign_top #(
  parameter int CTKN_CNT_W   = 4,    // 16 tokens make a blanking period
  parameter int SRCH_TIMER_W = 23    // about 100 ms at 74.25 MHz
) (
  input  logic                  clk,
  input  logic                  rst,
  input  phasealign_pkg::word_t sdata,        // captured 10-bit word
  input  logic                  psdone,
  input  logic                  dcm_ovflw,
  output logic                  psen,
  output logic                  psincdec,
  output logic                  psaligned,
  output logic                  psalgnerr,
  output logic                  found_vld_openeye
);

  logic rcvd_ctkn;
  logic blnkbgn;
  logic srch_rst;
  logic cnt_rst;
  logic srch_tout;
  logic cnt_tout;

  align_step_if step_bus ();            // fsm <-> tracker

  assign found_vld_openeye = step_bus.found_vld_openeye;

  ////////////////////////////////
  // datapath
  ////////////////////////////////
  ctrl_token_detect ctkn_det_i (
    .clk       (clk),
    .rst       (rst),
    .sdata     (sdata),
    .rcvd_ctkn (rcvd_ctkn),
    .blnkbgn   (blnkbgn)
  );

  blank_timers #(
    .CTKN_CNT_W   (CTKN_CNT_W),
    .SRCH_TIMER_W (SRCH_TIMER_W)
  ) timers_i (
    .clk       (clk),
    .rst       (rst),
    .srch_rst  (srch_rst),
    .cnt_rst   (cnt_rst),
    .srch_tout (srch_tout),
    .cnt_tout  (cnt_tout)
  );

  phase_tracker tracker_i (
    .clk  (clk),
    .rst  (rst),
    .step (step_bus.tracker)
  );

  ////////////////////////////////
  // control
  ////////////////////////////////
  align_fsm fsm_i (
    .clk       (clk),
    .rst       (rst),
    .rcvd_ctkn (rcvd_ctkn),
    .blnkbgn   (blnkbgn),
    .srch_tout (srch_tout),
    .cnt_tout  (cnt_tout),
    .psdone    (psdone),
    .dcm_ovflw (dcm_ovflw),
    .srch_rst  (srch_rst),
    .cnt_rst   (cnt_rst),
    .psen      (psen),
    .psincdec  (psincdec),
    .psaligned (psaligned),
    .psalgnerr (psalgnerr),
    .step      (step_bus.fsm)
  );

endmodule
